/* verilog/mbus_bridge_pkg.sv */
// Shared constants, response codes and controller states for the bus bridge
package mbus_bridge_pkg;

	// Leading bytes of the two outbound message types
	localparam logic [7:0] rx_flag_byte = 8'h42;
	localparam logic [7:0] ack_flag_byte = 8'h41;

	localparam int word_bytes = 4;
	localparam int header_bytes = 2;

	// Bit positions inside the rx status byte
	localparam int status_fail_bit = 1;
	localparam int status_bcast_bit = 0;

	typedef enum logic [7:0] {
		ack_ok = 8'd0,
		nak_tx_fail = 8'd1,
		nak_malformed = 8'd2
	} resp_code_e;

	typedef enum logic [3:0] {
		idle,
		tx_addr,
		tx_data,
		tx_req,
		tx_wait_drop,
		tx_resp,
		rx_flag,
		rx_tag,
		rx_word,
		rx_ack_drop,
		rx_status,
		respond
	} ctrl_state_e;

endpackage

/* verilog/byte_stream_if.sv */
// Framed valid/ready byte stream between blocks of the bridge
`timescale 1ns/100ps

interface byte_stream_if;
	logic [7:0] data;
	logic valid;
	logic last;
	logic ready;

	modport source (
		output data,
		output valid,
		output last,
		input ready
	);

	modport sink (
		input data,
		input valid,
		input last,
		output ready
	);
endinterface

/* verilog/frame_header_decoder.sv */
// Header decoder, strips event id and flag byte off host frames and passes the payload on
`timescale 1ns/100ps

module frame_header_decoder (
	input logic clk,
	input logic reset,
	input logic [7:0] host_in_data,
	input logic host_in_valid,
	input logic host_in_last,
	output logic host_in_ready,
	byte_stream_if.source payload,
	output logic header_done,
	output logic [7:0] event_id,
	output logic is_fragment_flag,
	input logic header_clear
);
	import mbus_bridge_pkg::*;

	logic hdr_cnt;
	logic payload_ended;
	logic hdr_accept;

	assign hdr_accept = ~header_done & host_in_valid;

	// Payload rides straight through once the header is in
	assign payload.data = host_in_data;
	assign payload.last = host_in_last;
	assign payload.valid = header_done & ~payload_ended & host_in_valid;
	assign host_in_ready = header_done ? (payload.ready & ~payload_ended) : 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			hdr_cnt <= 1'b0;
			header_done <= 1'b0;
			payload_ended <= 1'b0;
		end else if (header_clear) begin
			hdr_cnt <= 1'b0;
			header_done <= 1'b0;
			payload_ended <= 1'b0;
		end else begin
			if (hdr_accept) begin
				// A frame that ends within its header is thrown away
				if (host_in_last) begin
					hdr_cnt <= 1'b0;
				end else if (hdr_cnt == 1'(header_bytes - 1)) begin
					hdr_cnt <= 1'b0;
					header_done <= 1'b1;
				end else begin
					hdr_cnt <= hdr_cnt + 1'b1;
				end
			end
			if (payload.valid && payload.ready && payload.last)
				payload_ended <= 1'b1;
		end
	end

	// Fragment flag is bit 0 of the flag byte
	always_ff @(posedge clk) begin
		if (hdr_accept) begin
			if (hdr_cnt == 1'b0)
				event_id <= host_in_data;
			else
				is_fragment_flag <= host_in_data[0];
		end
	end

endmodule

/* verilog/ack_generator.sv */
// ACK/NAK generator, sends flag byte, event id and response code as one frame
`timescale 1ns/100ps

module ack_generator (
	input logic clk,
	input logic reset,
	input logic resp_start,
	input mbus_bridge_pkg::resp_code_e resp_code,
	input logic [7:0] resp_eid,
	output logic resp_busy,
	byte_stream_if.source msg
);
	import mbus_bridge_pkg::*;

	logic [1:0] byte_idx;
	resp_code_e code_q;
	logic [7:0] eid_q;
	logic msg_xfer;

	assign msg_xfer = msg.valid & msg.ready;
	assign msg.valid = resp_busy;
	assign msg.last = (byte_idx == 2'd2);

	always_comb begin
		case (byte_idx)
			2'd0: msg.data = ack_flag_byte;
			2'd1: msg.data = eid_q;
			default: msg.data = code_q;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			resp_busy <= 1'b0;
			byte_idx <= 2'd0;
		end else if (resp_start && !resp_busy) begin
			resp_busy <= 1'b1;
			byte_idx <= 2'd0;
		end else if (msg_xfer) begin
			if (msg.last)
				resp_busy <= 1'b0;
			byte_idx <= byte_idx + 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (resp_start && !resp_busy) begin
			code_q <= resp_code;
			eid_q <= resp_eid;
		end
	end

endmodule

/* verilog/host_frame_merge.sv */
// Outbound merge, locks the host stream to one message frame at a time
`timescale 1ns/100ps

module host_frame_merge (
	input logic clk,
	input logic reset,
	byte_stream_if.sink rx_msg,
	byte_stream_if.sink ack_msg,
	output logic [7:0] host_out_data,
	output logic host_out_valid,
	output logic host_out_last,
	input logic host_out_ready
);

	logic locked;
	logic sel_ack;
	logic grant_ack;

	// ACK messages win when both sources wait at a boundary
	assign grant_ack = locked ? sel_ack : ack_msg.valid;

	assign host_out_valid = grant_ack ? ack_msg.valid : rx_msg.valid;
	assign host_out_data = grant_ack ? ack_msg.data : rx_msg.data;
	assign host_out_last = grant_ack ? ack_msg.last : rx_msg.last;

	assign ack_msg.ready = grant_ack & host_out_ready;
	assign rx_msg.ready = ~grant_ack & host_out_ready;

	// Lock as soon as a byte is offered so a stalled byte never changes
	always_ff @(posedge clk) begin
		if (reset) begin
			locked <= 1'b0;
			sel_ack <= 1'b0;
		end else if (host_out_valid && host_out_ready && host_out_last) begin
			locked <= 1'b0;
		end else if (host_out_valid) begin
			locked <= 1'b1;
			sel_ack <= grant_ack;
		end
	end

endmodule

/* verilog/mbus_bridge_ctrl.sv */
// Bridge controller, assembles tx words, runs layer handshakes and serializes rx messages
`timescale 1ns/100ps

module mbus_bridge_ctrl (
	input logic clk,
	input logic reset,
	byte_stream_if.sink payload,
	input logic header_done,
	input logic [7:0] event_id,
	output logic header_clear,
	byte_stream_if.source rx_msg,
	output logic resp_start,
	output mbus_bridge_pkg::resp_code_e resp_code,
	output logic [7:0] resp_eid,
	input logic resp_busy,
	input logic [7:0] time_tag,
	output logic tag_incr,
	output logic [31:0] tx_addr,
	output logic [31:0] tx_data,
	output logic tx_pend,
	output logic tx_req,
	input logic tx_ack,
	input logic tx_succ,
	input logic tx_fail,
	output logic tx_resp_ack,
	input logic [31:0] rx_addr,
	input logic [31:0] rx_data,
	input logic rx_req,
	input logic rx_pend,
	input logic rx_fail,
	input logic rx_broadcast,
	output logic rx_ack
);
	import mbus_bridge_pkg::*;

	// tx_addr, tx_data and tx_req states share names with layer ports, so use package scope
	ctrl_state_e state, state_next;
	logic [1:0] rx_req_sync, succ_sync, fail_sync;
	logic rx_req_s, tx_succ_s, tx_fail_s;
	logic [1:0] cnt;
	logic [3:0] byte_cnt;
	logic [63:0] sr;
	logic first_word, rx_pend_q, fail_acc, bcast_acc;
	logic [7:0] status_byte;
	logic pay_xfer, rx_xfer, word_done, ser_busy, rx_load, malformed;

	assign rx_req_s = rx_req_sync[1];
	assign tx_succ_s = succ_sync[1];
	assign tx_fail_s = fail_sync[1];
	assign pay_xfer = payload.valid & payload.ready;
	assign rx_xfer = rx_msg.valid & rx_msg.ready;
	assign word_done = (cnt == 2'(word_bytes - 1));
	assign ser_busy = (byte_cnt != 4'd0);
	assign rx_load = (state == rx_word) & rx_req_s & ~ser_busy;
	// Last byte inside the address or mid-word means a bad frame
	assign malformed = pay_xfer & payload.last &
		((state == mbus_bridge_pkg::tx_addr) |
		((state == mbus_bridge_pkg::tx_data) & ~word_done));

	assign payload.ready = (state == mbus_bridge_pkg::tx_addr) |
		(state == mbus_bridge_pkg::tx_data);
	assign tx_req = (state == mbus_bridge_pkg::tx_req);
	assign rx_ack = (state == rx_ack_drop);
	assign resp_start = (state == respond) & ~resp_busy;
	assign header_clear = resp_start;
	assign resp_eid = event_id;

	always_comb begin
		status_byte = 8'h00;
		status_byte[status_fail_bit] = fail_acc;
		status_byte[status_bcast_bit] = bcast_acc;
	end

	// Outbound rx message byte
	always_comb begin
		rx_msg.valid = 1'b0;
		rx_msg.last = 1'b0;
		rx_msg.data = sr[63:56];
		case (state)
			rx_flag: begin
				rx_msg.valid = 1'b1;
				rx_msg.data = rx_flag_byte;
			end
			rx_tag: begin
				rx_msg.valid = 1'b1;
				rx_msg.data = time_tag;
			end
			rx_word, rx_ack_drop: rx_msg.valid = ser_busy;
			rx_status: begin
				rx_msg.valid = 1'b1;
				if (!ser_busy) begin
					rx_msg.data = status_byte;
					rx_msg.last = 1'b1;
				end
			end
			default: rx_msg.valid = 1'b0;
		endcase
	end

	always_comb begin
		state_next = state;
		case (state)
			idle: begin
				// Incoming rx traffic goes ahead of a waiting transmit
				if (rx_req_s)
					state_next = rx_flag;
				else if (header_done)
					state_next = mbus_bridge_pkg::tx_addr;
			end
			mbus_bridge_pkg::tx_addr: begin
				if (malformed)
					state_next = respond;
				else if (pay_xfer && word_done)
					state_next = mbus_bridge_pkg::tx_data;
			end
			mbus_bridge_pkg::tx_data: begin
				if (malformed)
					state_next = respond;
				else if (pay_xfer && word_done)
					state_next = mbus_bridge_pkg::tx_req;
			end
			mbus_bridge_pkg::tx_req: if (tx_ack) state_next = tx_wait_drop;
			tx_wait_drop: begin
				if (!tx_ack)
					state_next = tx_pend ? mbus_bridge_pkg::tx_data : tx_resp;
			end
			tx_resp: if (tx_succ_s || tx_fail_s) state_next = respond;
			respond: if (!resp_busy) state_next = idle;
			rx_flag: if (rx_xfer) state_next = rx_tag;
			rx_tag: if (rx_xfer) state_next = rx_word;
			rx_word: if (rx_load) state_next = rx_ack_drop;
			rx_ack_drop: if (!rx_req_s) state_next = rx_pend_q ? rx_word : rx_status;
			rx_status: if (rx_xfer && !ser_busy) state_next = idle;
			default: state_next = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			rx_req_sync <= 2'b00;
			succ_sync <= 2'b00;
			fail_sync <= 2'b00;
			tag_incr <= 1'b0;
			tx_resp_ack <= 1'b0;
			tx_pend <= 1'b0;
			cnt <= 2'd0;
			byte_cnt <= 4'd0;
			first_word <= 1'b1;
			rx_pend_q <= 1'b0;
			fail_acc <= 1'b0;
			bcast_acc <= 1'b0;
		end else begin
			state <= state_next;
			rx_req_sync <= {rx_req_sync[0], rx_req};
			succ_sync <= {succ_sync[0], tx_succ};
			fail_sync <= {fail_sync[0], tx_fail};
			tag_incr <= (state == rx_tag) & rx_xfer;
			tx_resp_ack <= (state == tx_resp) & (tx_succ_s | tx_fail_s);
			if (state == idle)
				cnt <= 2'd0;
			else if (pay_xfer)
				cnt <= word_done ? 2'd0 : cnt + 2'd1;
			// More payload after a full word means the word is pending
			if ((state == mbus_bridge_pkg::tx_data) && pay_xfer && word_done)
				tx_pend <= ~payload.last;
			if (state == idle) begin
				first_word <= 1'b1;
				fail_acc <= 1'b0;
				bcast_acc <= 1'b0;
			end else if (rx_load) begin
				first_word <= 1'b0;
				rx_pend_q <= rx_pend;
				fail_acc <= fail_acc | rx_fail;
				bcast_acc <= bcast_acc | rx_broadcast;
			end
			if (rx_load)
				byte_cnt <= first_word ? 4'(2 * word_bytes) : 4'(word_bytes);
			else if (rx_xfer && ser_busy)
				byte_cnt <= byte_cnt - 4'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (pay_xfer && state == mbus_bridge_pkg::tx_addr)
			tx_addr <= {tx_addr[23:0], payload.data};
		if (pay_xfer && state == mbus_bridge_pkg::tx_data)
			tx_data <= {tx_data[23:0], payload.data};
		// Address goes out only with the first word of a message
		if (rx_load)
			sr <= first_word ? {rx_addr, rx_data} : {rx_data, 32'h0000_0000};
		else if (rx_xfer && ser_busy)
			sr <= {sr[55:0], 8'h00};
		if (malformed)
			resp_code <= nak_malformed;
		else if (state == tx_resp && (tx_succ_s || tx_fail_s))
			resp_code <= tx_fail_s ? nak_tx_fail : ack_ok;
	end

endmodule

/* verilog/mbus_bridge_top.sv */
// Bridge top level, host byte streams on one side and layer controller words on the other
`timescale 1ns/100ps

module mbus_bridge_top (
	input logic clk,
	input logic reset,
	input logic [7:0] host_in_data,
	input logic host_in_valid,
	input logic host_in_last,
	output logic host_in_ready,
	output logic [7:0] host_out_data,
	output logic host_out_valid,
	output logic host_out_last,
	input logic host_out_ready,
	input logic [7:0] time_tag,
	output logic tag_incr,
	output logic [31:0] tx_addr,
	output logic [31:0] tx_data,
	output logic tx_pend,
	output logic tx_req,
	input logic tx_ack,
	input logic tx_succ,
	input logic tx_fail,
	output logic tx_resp_ack,
	input logic [31:0] rx_addr,
	input logic [31:0] rx_data,
	input logic rx_req,
	input logic rx_pend,
	input logic rx_fail,
	input logic rx_broadcast,
	output logic rx_ack
);
	import mbus_bridge_pkg::*;

	byte_stream_if hdr_payload ();
	byte_stream_if rx_msg ();
	byte_stream_if ack_msg ();

	logic header_done, header_clear, is_fragment_flag;
	logic [7:0] event_id, resp_eid;
	logic resp_start, resp_busy;
	resp_code_e resp_code;

	frame_header_decoder frame_header_decoder_inst (
		.clk, .reset, .host_in_data, .host_in_valid, .host_in_last, .host_in_ready,
		.payload(hdr_payload.source), .header_done, .event_id, .is_fragment_flag,
		.header_clear
	);

	ack_generator ack_generator_inst (
		.clk, .reset, .resp_start, .resp_code, .resp_eid, .resp_busy,
		.msg(ack_msg.source)
	);

	host_frame_merge host_frame_merge_inst (
		.clk, .reset, .rx_msg(rx_msg.sink), .ack_msg(ack_msg.sink),
		.host_out_data, .host_out_valid, .host_out_last, .host_out_ready
	);

	mbus_bridge_ctrl mbus_bridge_ctrl_inst (
		.clk, .reset, .payload(hdr_payload.sink), .header_done, .event_id, .header_clear,
		.rx_msg(rx_msg.source), .resp_start, .resp_code, .resp_eid, .resp_busy,
		.time_tag, .tag_incr, .tx_addr, .tx_data, .tx_pend, .tx_req, .tx_ack, .tx_succ,
		.tx_fail, .tx_resp_ack, .rx_addr, .rx_data, .rx_req, .rx_pend, .rx_fail,
		.rx_broadcast, .rx_ack
	);

endmodule

/* sim/mbus_bridge_chk.sv */
// Concurrent assertions on layer handshakes and host output frames of the bridge
`timescale 1ns/100ps

module mbus_bridge_chk (
	input logic clk,
	input logic reset,
	input logic tx_req,
	input logic tx_ack,
	input logic rx_req,
	input logic rx_ack,
	input logic [7:0] host_out_data,
	input logic host_out_valid,
	input logic host_out_last,
	input logic host_out_ready,
	input logic grant_ack
);

	logic mid_frame;
	logic frame_src;
	int fail_count = 0;

	// Source of the frame currently on the host output
	always_ff @(posedge clk) begin
		if (reset) begin
			mid_frame <= 1'b0;
			frame_src <= 1'b0;
		end else if (host_out_valid && host_out_ready) begin
			mid_frame <= ~host_out_last;
			frame_src <= grant_ack;
		end
	end

	a_tx_req_hold: assert property (@(posedge clk) disable iff (reset)
		tx_req && !tx_ack |=> tx_req)
		else begin
			fail_count++;
			$error("tx_req dropped before tx_ack");
		end

	// rx_ack is raised on the edge after a cycle with rx_req high
	a_rx_ack_rise: assert property (@(posedge clk) disable iff (reset)
		$rose(rx_ack) |-> $past(rx_req))
		else begin
			fail_count++;
			$error("rx_ack rose without rx_req");
		end

	a_out_stall: assert property (@(posedge clk) disable iff (reset)
		host_out_valid && !host_out_ready |=>
		host_out_valid && $stable(host_out_data) && $stable(host_out_last))
		else begin
			fail_count++;
			$error("host output changed under stall");
		end

	a_no_switch: assert property (@(posedge clk) disable iff (reset)
		mid_frame |-> grant_ack == frame_src)
		else begin
			fail_count++;
			$error("host output switched source inside a frame");
		end

endmodule

bind mbus_bridge_top mbus_bridge_chk mbus_bridge_chk_inst (
	.clk, .reset, .tx_req, .tx_ack, .rx_req, .rx_ack,
	.host_out_data, .host_out_valid, .host_out_last, .host_out_ready,
	.grant_ack(host_frame_merge_inst.grant_ack)
);

/* sim/mbus_bridge_tb.sv */
// Testbench for the bus bridge with host, layer controller and scoreboard models
`timescale 1ns/100ps

module mbus_bridge_tb;
	import mbus_bridge_pkg::*;

	localparam int num_tests = 6;
	localparam int cycles_per_test = 2000;
	localparam logic [7:0] tag_start = 8'h30;

	logic clk = 1'b0;
	logic reset;
	logic [7:0] host_in_data, host_out_data, time_tag;
	logic host_in_valid, host_in_last, host_in_ready;
	logic host_out_valid, host_out_last, host_out_ready;
	logic tag_incr, tx_pend, tx_req, tx_ack, tx_succ, tx_fail, tx_resp_ack;
	logic [31:0] tx_addr, tx_data, rx_addr, rx_data;
	logic rx_req, rx_pend, rx_fail, rx_broadcast, rx_ack;

	int errors = 0;
	int checks = 0;
	int err_base = 0;
	int assert_seen = 0;
	int msg_count = 0;
	int incr_count = 0;
	int pending_acks = 0;
	int force_result = 0;
	// Entry is event id, pend, address and data
	logic [72:0] tx_exp_q[$];
	logic [15:0] ack_exp_q[$];
	logic [7:0] rx_exp_q[$];
	int rx_len_q[$];
	logic [7:0] got_q[$];

	mbus_bridge_top mbus_bridge_top_inst (.*);

	always #5 clk = ~clk;

	initial begin
		#(num_tests * cycles_per_test * 10);
		$display("Timeout, the run did not finish within %0d cycles", num_tests * cycles_per_test);
		$display("Simulation FAILED");
		$finish;
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic send_frame(input int nwords, input int ragged);
		logic [7:0] bytes[$];
		logic [7:0] eid;
		logic [31:0] addr, data;
		eid = 8'($urandom);
		addr = $urandom;
		pending_acks++;
		bytes = {eid, 8'($urandom), addr[31:24], addr[23:16], addr[15:8], addr[7:0]};
		for (int w = 0; w < nwords; w++) begin
			data = $urandom;
			bytes = {bytes, data[31:24], data[23:16], data[15:8], data[7:0]};
			tx_exp_q.push_back({eid, (w < nwords - 1) ? 1'b1 : 1'b0, addr, data});
		end
		for (int r = 0; r < ragged; r++)
			bytes.push_back(8'($urandom));
		for (int i = 0; i < bytes.size(); i++) begin
			@(negedge clk);
			host_in_valid = 1'b1;
			host_in_data = bytes[i];
			host_in_last = (i == bytes.size() - 1);
			#1;
			while (!host_in_ready) begin
				@(negedge clk);
				#1;
			end
		end
		@(negedge clk);
		host_in_valid = 1'b0;
		host_in_last = 1'b0;
		if (nwords == 0 || ragged != 0)
			ack_exp_q.push_back({eid, 8'(nak_malformed)});
		repeat ($urandom % 4) @(negedge clk);
	endtask

	task automatic send_rx_msg(input int nwords);
		logic [31:0] addr;
		logic [31:0] words[5];
		logic [4:0] fails, bcasts;
		addr = $urandom;
		fails = '0;
		bcasts = '0;
		rx_exp_q.push_back(rx_flag_byte);
		rx_exp_q.push_back(8'(tag_start + msg_count));
		for (int b = 3; b >= 0; b--)
			rx_exp_q.push_back(addr[8 * b +: 8]);
		for (int w = 0; w < nwords; w++) begin
			words[w] = $urandom;
			fails[w] = ($urandom % 5 == 0);
			bcasts[w] = ($urandom % 5 == 0);
			for (int b = 3; b >= 0; b--)
				rx_exp_q.push_back(words[w][8 * b +: 8]);
		end
		rx_exp_q.push_back({6'd0, |fails, |bcasts});
		rx_len_q.push_back(7 + 4 * nwords);
		msg_count++;
		for (int w = 0; w < nwords; w++) begin
			@(negedge clk);
			rx_addr = addr;
			rx_data = words[w];
			rx_pend = (w < nwords - 1);
			rx_fail = fails[w];
			rx_broadcast = bcasts[w];
			rx_req = 1'b1;
			while (!rx_ack) @(negedge clk);
			rx_req = 1'b0;
			while (rx_ack) @(negedge clk);
			repeat ($urandom % 3) @(negedge clk);
		end
	endtask

	// Layer controller side of the transmit handshake
	initial begin
		logic [72:0] exp;
		logic fail;
		forever begin
			@(negedge clk);
			if (tx_req) begin
				if (tx_exp_q.size() == 0) begin
					errors++;
					$display("Unexpected tx_req at %0t with no word outstanding", $time);
					exp = {8'h00, tx_pend, tx_addr, tx_data};
				end else begin
					exp = tx_exp_q.pop_front();
					check_val("tx_addr", tx_addr, exp[63:32]);
					check_val("tx_data", tx_data, exp[31:0]);
					check_val("tx_pend", tx_pend, exp[64]);
				end
				repeat ($urandom % 4) @(negedge clk);
				tx_ack = 1'b1;
				while (tx_req) @(negedge clk);
				repeat ($urandom % 3) @(negedge clk);
				tx_ack = 1'b0;
				if (!exp[64]) begin
					repeat ($urandom % 4) @(negedge clk);
					fail = (force_result == 2) || (force_result == 0 && $urandom % 3 == 0);
					ack_exp_q.push_back({exp[72:65], fail ? 8'(nak_tx_fail) : 8'(ack_ok)});
					tx_succ = ~fail;
					tx_fail = fail;
					while (!tx_resp_ack) @(negedge clk);
					tx_succ = 1'b0;
					tx_fail = 1'b0;
				end
			end
		end
	end

	always @(negedge clk) begin
		if (!reset && tag_incr) begin
			time_tag <= time_tag + 8'd1;
			incr_count++;
		end
	end

	task automatic compare_frame();
		logic [15:0] ack;
		int len;
		if (got_q[0] == ack_flag_byte) begin
			pending_acks--;
			if (ack_exp_q.size() == 0 || got_q.size() != 3) begin
				errors++;
				$display("ACK frame of %0d bytes at %0t was not expected", got_q.size(), $time);
			end else begin
				ack = ack_exp_q.pop_front();
				check_val("ack event id", got_q[1], ack[15:8]);
				check_val("ack code", got_q[2], ack[7:0]);
			end
		end else if (got_q[0] == rx_flag_byte && rx_len_q.size() != 0) begin
			len = rx_len_q.pop_front();
			if (got_q.size() != len) begin
				errors++;
				$display("Rx frame at %0t has %0d bytes instead of %0d", $time, got_q.size(), len);
			end
			for (int i = 0; i < len; i++)
				check_val("rx message byte", (i < got_q.size()) ? got_q[i] : 8'hxx,
					rx_exp_q.pop_front());
		end else begin
			errors++;
			$display("Unexpected frame starting with %h at %0t", got_q[0], $time);
		end
	endtask

	// Host receiver with random back-pressure
	initial begin
		@(negedge clk);
		forever begin
			@(negedge clk);
			host_out_ready = ($urandom % 4 != 0);
			#1;
			if (host_out_valid && host_out_ready) begin
				got_q.push_back(host_out_data);
				if (host_out_last) begin
					compare_frame();
					got_q.delete();
				end
			end
		end
	end

	task automatic finish_test(input int num, input string name);
		wait (pending_acks == 0 && rx_len_q.size() == 0 && tx_exp_q.size() == 0);
		repeat (4) @(negedge clk);
		errors += mbus_bridge_top_inst.mbus_bridge_chk_inst.fail_count - assert_seen;
		assert_seen = mbus_bridge_top_inst.mbus_bridge_chk_inst.fail_count;
		$display("Test %0d %s done with %0d errors", num, name, errors - err_base);
		err_base = errors;
	endtask

	initial begin
		void'($urandom(32'h89f5_4901));
		reset = 1'b1;
		{host_in_data, host_in_valid, host_in_last, host_out_ready} = '0;
		{tx_ack, tx_succ, tx_fail, rx_req, rx_pend, rx_fail, rx_broadcast} = '0;
		rx_addr = '0;
		rx_data = '0;
		time_tag = tag_start;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		force_result = 1;
		send_frame(1, 0);
		finish_test(1, "single word transmit");
		repeat (6) send_frame(2 + $urandom % 4, 0);
		finish_test(2, "multi word transmit");
		force_result = 2;
		send_frame(1 + $urandom % 3, 0);
		finish_test(3, "transmit failure");
		send_frame(0, 0);
		send_frame(0, 1 + $urandom % 3);
		send_frame(0, 1 + $urandom % 3);
		finish_test(4, "malformed frames");
		repeat (8) send_rx_msg(1 + $urandom % 5);
		finish_test(5, "rx messages");
		force_result = 0;
		fork
			repeat (6) send_frame(1 + $urandom % 4, 0);
			repeat (6) send_rx_msg(1 + $urandom % 5);
		join
		finish_test(6, "overlapping traffic");
		check_val("tag_incr count", incr_count, msg_count);
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* files.f */
verilog/mbus_bridge_pkg.sv
verilog/byte_stream_if.sv
verilog/frame_header_decoder.sv
verilog/ack_generator.sv
verilog/host_frame_merge.sv
verilog/mbus_bridge_ctrl.sv
verilog/mbus_bridge_top.sv
sim/mbus_bridge_chk.sv
sim/mbus_bridge_tb.sv

/* Bender.yml */
package:
  name: mbus_bridge

sources:
  - files:
      - verilog/mbus_bridge_pkg.sv
      - verilog/byte_stream_if.sv
      - verilog/frame_header_decoder.sv
      - verilog/ack_generator.sv
      - verilog/host_frame_merge.sv
      - verilog/mbus_bridge_ctrl.sv
      - verilog/mbus_bridge_top.sv
  - target: simulation
    files:
      - sim/mbus_bridge_chk.sv
      - sim/mbus_bridge_tb.sv
